// File: logic/axis_pkg.sv
// Stream beat types and sizes
package axis_pkg;

    // ****************************
    // Stream widths
    // ****************************

    // Host side beat
    localparam int S_DATA_W = 32;
    localparam int S_KEEP_W = S_DATA_W / 8;

    // DMA side beat, two host beats wide
    localparam int M_DATA_W = 64;
    localparam int M_KEEP_W = M_DATA_W / 8;

    // ****************************
    // Input FIFO sizing
    // ****************************

    // Depth must stay a power of two
    localparam int FIFO_DEPTH = 16;
    // Pointers wrap on their own width
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    // Level counts 0 to FIFO_DEPTH inclusive
    localparam int FIFO_LVL_W = FIFO_PTR_W + 1;

    // One host beat, 37 bits
    typedef struct packed {
        logic [S_DATA_W-1:0] data;
        logic [S_KEEP_W-1:0] keep;
        logic                last;
    } axis32_t;

    // One DMA beat, 73 bits
    typedef struct packed {
        logic [M_DATA_W-1:0] data;
        logic [M_KEEP_W-1:0] keep;
        logic                last;
    } axis64_t;

    // Pairing state of the upsizer
    typedef enum logic {
        UP_EMPTY = 1'b0,
        UP_HALF  = 1'b1
    } upsize_state_e;

endpackage

// File: logic/csr_pkg.sv
// Register bus types and map
package csr_pkg;

    // ****************************
    // Wishbone bus
    // ****************************

    // Byte address over four word registers
    localparam int CSR_ADR_W = 4;
    localparam int CSR_DAT_W = 32;

    // Master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [CSR_ADR_W-1:0] adr;
        logic [CSR_DAT_W-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                 ack;
        logic [CSR_DAT_W-1:0] dat;
    } wb_rsp_t;

    // ****************************
    // Register map
    // ****************************
    typedef enum logic [CSR_ADR_W-1:0] {
        CTRL       = 4'h0,
        STATUS     = 4'h4,
        PKT_COUNT  = 4'h8,
        BYTE_COUNT = 4'hC
    } csr_reg_e;

    // CTRL fields
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;

endpackage

// File: logic/fromhost_fifo.sv
// Host beat input FIFO
`timescale 1ns/1ps

module fromhost_fifo
    import axis_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Host side
    input  axis32_t               s_beat,
    input  logic                  s_valid,
    output logic                  s_ready,
    // Upsizer side, first word falls through
    output axis32_t               fifo_beat,
    output logic                  fifo_valid,
    input  logic                  fifo_ready,
    // Occupancy for the status register
    output logic [FIFO_LVL_W-1:0] level
);

    axis32_t               mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_LVL_W-1:0] count;
    logic                  wr_en;
    logic                  rd_en;

    // Handshakes on both ports
    assign wr_en = s_valid && s_ready;
    assign rd_en = fifo_valid && fifo_ready;

    // Space left, or data waiting
    assign s_ready    = (count != FIFO_LVL_W'(FIFO_DEPTH));
    assign fifo_valid = (count != '0);
    // Head entry shows without a read
    assign fifo_beat  = mem[rd_ptr];
    assign level      = count;

    // Storage, payload only
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_beat;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Read and write together leave the level alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Pointers meeting with data inside means full, no write then
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_ptr == rd_ptr) && (count != '0) |-> !wr_en);

    // Pointers meeting with room left means empty, no read then
    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_ptr == rd_ptr) && (count != FIFO_LVL_W'(FIFO_DEPTH)) |-> !rd_en);

endmodule

// File: logic/axis_upsize_32to64.sv
// 32 to 64 bit stream upsizer
`timescale 1ns/1ps

module axis_upsize_32to64
    import axis_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // Gate for new packets
    input  logic    enable,
    // From the input FIFO
    input  axis32_t fifo_beat,
    input  logic    fifo_valid,
    output logic    fifo_ready,
    // DMA write side
    output axis64_t m_beat,
    output logic    m_valid,
    input  logic    m_ready
);

    upsize_state_e       state;
    logic                pkt_start;
    logic [S_DATA_W-1:0] low_data;
    logic [S_KEEP_W-1:0] low_keep;
    axis64_t             out_beat;
    logic                out_valid;
    axis64_t             packed_beat;
    logic                out_free;
    logic                gate_ok;
    logic                take_ok;
    logic                in_fire;
    logic                load_out;

    // ****************************
    // Acceptance
    // ****************************

    // Output register empty or draining this cycle
    assign out_free = !out_valid || m_ready;
    // Disabled engine still finishes the packet in flight
    assign gate_ok  = enable || !pkt_start;

    always_comb begin
        if (state == UP_HALF) begin
            // Second half always lands in the output register
            take_ok = out_free;
        end else begin
            // A lone last beat also needs the output register
            take_ok = !fifo_beat.last || out_free;
        end
    end

    assign fifo_ready = gate_ok && take_ok;
    assign in_fire    = fifo_valid && fifo_ready;
    // Pair completes, or odd packet ends on a low half
    assign load_out   = in_fire && ((state == UP_HALF) || fifo_beat.last);

    // ****************************
    // Packing
    // ****************************
    always_comb begin
        packed_beat.last = fifo_beat.last;
        if (state == UP_HALF) begin
            // Held beat low, new beat high
            packed_beat.data = {fifo_beat.data, low_data};
            packed_beat.keep = {fifo_beat.keep, low_keep};
        end else begin
            // Odd tail, upper half empty
            packed_beat.data = {{S_DATA_W{1'b0}}, fifo_beat.data};
            packed_beat.keep = {{S_KEEP_W{1'b0}}, fifo_beat.keep};
        end
    end

    // Low half holding stage
    always_ff @(posedge clk) begin
        if (in_fire && (state == UP_EMPTY)) begin
            low_data <= fifo_beat.data;
            low_keep <= fifo_beat.keep;
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat <= packed_beat;
        end
    end

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= UP_EMPTY;
            pkt_start <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                // Next accepted beat opens a packet after a last
                pkt_start <= fifo_beat.last;
                if ((state == UP_EMPTY) && !fifo_beat.last) begin
                    state <= UP_HALF;
                end else begin
                    state <= UP_EMPTY;
                end
            end
            if (load_out) begin
                out_valid <= 1'b1;
            end else if (m_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    assign m_beat  = out_beat;
    assign m_valid = out_valid;

    // Stalled beat held steady until taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

// File: logic/dma_stream_csr.sv
// Receive path control and status registers
`timescale 1ns/1ps

module dma_stream_csr
    import axis_pkg::*;
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // Wishbone classic slave
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    // Watched DMA side handshake
    input  axis64_t               m_beat,
    input  logic                  m_valid,
    input  logic                  m_ready,
    // FIFO occupancy
    input  logic [FIFO_LVL_W-1:0] level,
    // Packet gate to the upsizer
    output logic                  enable
);

    logic                 ack_q;
    logic [CSR_DAT_W-1:0] rd_q;
    logic                 en_q;
    logic [31:0]          pkt_count;
    logic [31:0]          byte_count;
    logic                 bus_hit;
    logic                 wr_ctrl;
    logic                 cnt_clr;
    logic                 m_fire;
    logic [CSR_DAT_W-1:0] rd_data;

    // ****************************
    // Bus decode
    // ****************************

    // First cycle of a request, ack follows on this edge
    assign bus_hit = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_ctrl = bus_hit && wb_req.we && (csr_reg_e'(wb_req.adr) == CTRL);
    // Clear pulse lasts the acknowledging edge only
    assign cnt_clr = wr_ctrl && wb_req.dat[CTRL_CLR_BIT];

    // Read mux
    always_comb begin
        rd_data = '0;
        case (csr_reg_e'(wb_req.adr))
            CTRL:       rd_data[CTRL_EN_BIT] = en_q;
            // Level in the low bits
            STATUS:     rd_data[FIFO_LVL_W-1:0] = level;
            PKT_COUNT:  rd_data = pkt_count;
            BYTE_COUNT: rd_data = byte_count;
            default:    rd_data = '0;
        endcase
    end

    // Ack, read data and CTRL
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            rd_q  <= '0;
            en_q  <= 1'b0;
        end else begin
            ack_q <= bus_hit;
            if (bus_hit && !wb_req.we) begin
                rd_q <= rd_data;
            end
            if (wr_ctrl) begin
                en_q <= wb_req.dat[CTRL_EN_BIT];
            end
        end
    end

    // ****************************
    // Traffic counters
    // ****************************
    assign m_fire = m_valid && m_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count  <= '0;
            byte_count <= '0;
        end else if (cnt_clr) begin
            pkt_count  <= '0;
            byte_count <= '0;
        end else if (m_fire) begin
            // Wrap silently at 32 bits
            if (m_beat.last) begin
                pkt_count <= pkt_count + 1'b1;
            end
            // One byte per set keep bit
            byte_count <= byte_count + 32'($countones(m_beat.keep));
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;
    assign enable     = en_q;

    // Master drops the strobe after ack so each request is acked once
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack_q |=> !(wb_req.cyc && wb_req.stb));

endmodule

// File: logic/fromhost_dma_if.sv
// Host to DMA receive path top level
`timescale 1ns/1ps

module fromhost_dma_if
    import axis_pkg::*;
    import csr_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // 32 bit host stream
    input  axis32_t s_beat,
    input  logic    s_valid,
    output logic    s_ready,
    // 64 bit DMA stream
    output axis64_t m_beat,
    output logic    m_valid,
    input  logic    m_ready,
    // Register bus
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    // FIFO to upsizer
    axis32_t               fifo_beat;
    logic                  fifo_valid;
    logic                  fifo_ready;
    // Register block links
    logic [FIFO_LVL_W-1:0] level;
    logic                  enable;

    // Input buffering
    fromhost_fifo fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .level      (level)
    );

    // Pair packing
    axis_upsize_32to64 upsize_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready)
    );

    // Control, status and counters
    dma_stream_csr csr_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .level   (level),
        .enable  (enable)
    );

endmodule

// File: sim/fromhost_dma_if_tb.sv
// Receive path testbench
`timescale 1ns/1ps

module fromhost_dma_if_tb
    import axis_pkg::*;
    import csr_pkg::*;
();

    // Bound on every handshake wait, in cycles
    localparam int WAIT_LIMIT   = 2000;
    // Window where a gated packet must stay invisible
    localparam int QUIET_CYCLES = 40;
    // m_ready patterns
    localparam int READY_HIGH   = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_RANDOM = 2;
    // CTRL write values
    localparam logic [31:0] EN_WORD  = 32'h1 << CTRL_EN_BIT;
    localparam logic [31:0] CLR_WORD = 32'h1 << CTRL_CLR_BIT;

    logic    clk;
    logic    rst_n;
    axis32_t s_beat;
    logic    s_valid;
    logic    s_ready;
    axis64_t m_beat;
    logic    m_valid;
    logic    m_ready;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // Reference model
    axis64_t exp_q[$];
    axis32_t hold_beat;
    logic    hold_valid;
    int      sent_beats;
    int      sent_pkts;

    int      ready_mode;
    logic    quiet;
    int      errors;
    int      timeouts;
    int      checked;

    fromhost_dma_if dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    always #5 clk = ~clk;

    // m_ready pattern generator
    always @(posedge clk) begin
        case (ready_mode)
            READY_LOW:    m_ready <= 1'b0;
            READY_RANDOM: m_ready <= 1'($urandom_range(1, 0));
            default:      m_ready <= 1'b1;
        endcase
    end

    // ******************************
    // Reference packing
    // ******************************

    // First beat low, second high, lone last beat alone in the low half
    function automatic void model_beat(input axis32_t b);
        axis64_t o;
        sent_beats++;
        if (b.last) begin
            sent_pkts++;
        end
        if (hold_valid) begin
            o.data = {b.data, hold_beat.data};
            o.keep = {b.keep, hold_beat.keep};
            o.last = b.last;
            exp_q.push_back(o);
            hold_valid = 1'b0;
        end else if (b.last) begin
            o.data = {32'h0, b.data};
            o.keep = {4'h0, b.keep};
            o.last = 1'b1;
            exp_q.push_back(o);
        end else begin
            hold_beat  = b;
            hold_valid = 1'b1;
        end
    endfunction

    // Watch both streams at each edge
    always @(posedge clk) begin
        axis64_t want;
        if (rst_n) begin
            if (s_valid && s_ready) begin
                model_beat(s_beat);
            end
            if (m_valid && m_ready) begin
                checked++;
                // Only a packet's final beat may be partial
                assert (m_beat.last || m_beat.keep == 8'hFF) else begin
                    errors++;
                    $display("mismatch at %0t: partial keep %h on a non-last beat",
                             $time, m_beat.keep);
                end
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("output beat at %0t with no input left to match it", $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (m_beat == want) else begin
                        errors++;
                        $display("mismatch at %0t: got %h/%h/%b, expected %h/%h/%b", $time,
                                 m_beat.data, m_beat.keep, m_beat.last,
                                 want.data, want.keep, want.last);
                    end
                end
            end
        end
    end

    // Nothing may come out while a packet is held back
    a_quiet_gate: assert property (@(posedge clk) disable iff (!rst_n) quiet |-> !m_valid)
        else begin
            errors++;
            $display("mismatch at %0t: output beat appeared while enable is off", $time);
        end

    // ******************************
    // Stimulus tasks
    // ******************************
    task automatic send_packet(input int len);
        axis32_t b;
        int      waits;
        for (int i = 0; i < len; i++) begin
            b.data = $urandom;
            b.keep = 4'hF;
            b.last = (i == len - 1);
            s_beat  <= b;
            s_valid <= 1'b1;
            waits = 0;
            do begin
                @(posedge clk);
                waits++;
            end while (!s_ready && waits < WAIT_LIMIT);
            if (!s_ready) begin
                timeouts++;
                $display("timeout at %0t: input beat %0d was never accepted", $time, i);
            end
        end
        s_valid <= 1'b0;
    endtask

    task automatic bus_cycle(input logic we, input csr_reg_e adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        wb_req_t req;
        int      waits;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        wb_req <= req;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
        end while (!wb_rsp.ack && waits < WAIT_LIMIT);
        if (!wb_rsp.ack) begin
            timeouts++;
            $display("timeout at %0t: register %h never acknowledged", $time, adr);
        end
        rdat = wb_rsp.dat;
        wb_req <= '0;
        // Idle cycle between requests
        @(posedge clk);
    endtask

    task automatic write_reg(input csr_reg_e adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic check_reg(input csr_reg_e adr, input logic [31:0] want, input string what);
        logic [31:0] rdat;
        bus_cycle(1'b0, adr, 32'h0, rdat);
        assert (rdat == want) else begin
            errors++;
            $display("mismatch at %0t: %s read %h, expected %h", $time, what, rdat, want);
        end
    endtask

    // Every sent beat has come out
    task automatic wait_drain();
        int waits;
        waits = 0;
        while ((exp_q.size() != 0 || hold_valid || m_valid) && waits < WAIT_LIMIT) begin
            @(posedge clk);
            waits++;
        end
        if (waits >= WAIT_LIMIT) begin
            timeouts++;
            $display("timeout at %0t: output did not drain, %0d beats missing",
                     $time, exp_q.size());
        end
        // Counters trail the last transfer by a cycle
        repeat (2) @(posedge clk);
    endtask

    task automatic wait_output_beat();
        int waits;
        waits = 0;
        do begin
            @(posedge clk);
            waits++;
        end while (!(m_valid && m_ready) && waits < WAIT_LIMIT);
        if (!(m_valid && m_ready)) begin
            timeouts++;
            $display("timeout at %0t: no output beat appeared", $time);
        end
    endtask

    // ******************************
    // Test sequence
    // ******************************
    initial begin
        logic [31:0] rdat;
        int          len;
        void'($urandom(77));
        clk        = 1'b0;
        rst_n      = 1'b0;
        s_beat     = '0;
        s_valid    = 1'b0;
        m_ready    = 1'b1;
        wb_req     = '0;
        ready_mode = READY_HIGH;
        quiet      = 1'b0;
        hold_beat  = '0;
        hold_valid = 1'b0;
        sent_beats = 0;
        sent_pkts  = 0;
        errors     = 0;
        timeouts   = 0;
        checked    = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Reset state, engine disabled
        assert (!m_valid && s_ready) else begin
            errors++;
            $display("mismatch at %0t: m_valid %b s_ready %b after reset", $time,
                     m_valid, s_ready);
        end
        check_reg(CTRL, 32'h0, "CTRL after reset");
        check_reg(PKT_COUNT, 32'h0, "PKT_COUNT after reset");
        check_reg(BYTE_COUNT, 32'h0, "BYTE_COUNT after reset");
        quiet <= 1'b1;
        send_packet(3);
        repeat (QUIET_CYCLES) @(posedge clk);
        quiet <= 1'b0;
        write_reg(CTRL, EN_WORD);
        wait_drain();

        // Even lengths at full rate
        for (int p = 0; p < 6; p++) begin
            len = 2 * $urandom_range(6, 1);
            send_packet(len);
        end
        wait_drain();

        // Odd lengths end on a half beat
        for (int p = 0; p < 6; p++) begin
            len = 2 * $urandom_range(4, 0) + 1;
            send_packet(len);
        end
        wait_drain();

        // Stalled output backs up the FIFO
        ready_mode <= READY_LOW;
        repeat (2) @(posedge clk);
        send_packet(10);
        bus_cycle(1'b0, STATUS, 32'h0, rdat);
        assert (rdat[FIFO_LVL_W-1:0] != '0) else begin
            errors++;
            $display("mismatch at %0t: STATUS level 0 while output is stalled", $time);
        end
        ready_mode <= READY_RANDOM;
        for (int p = 0; p < 24; p++) begin
            len = $urandom_range(12, 1);
            send_packet(len);
        end
        wait_drain();
        ready_mode <= READY_HIGH;
        repeat (2) @(posedge clk);

        // Traffic counters, then clear
        check_reg(PKT_COUNT, 32'(sent_pkts), "PKT_COUNT");
        check_reg(BYTE_COUNT, 32'(4 * sent_beats), "BYTE_COUNT");
        write_reg(CTRL, EN_WORD | CLR_WORD);
        check_reg(PKT_COUNT, 32'h0, "PKT_COUNT after clear");
        check_reg(BYTE_COUNT, 32'h0, "BYTE_COUNT after clear");
        check_reg(CTRL, EN_WORD, "CTRL after clear");
        sent_pkts  = 0;
        sent_beats = 0;

        // Disable in the middle of a packet
        fork
            send_packet(12);
            begin
                wait_output_beat();
                write_reg(CTRL, 32'h0);
            end
        join
        wait_drain();
        quiet <= 1'b1;
        send_packet(4);
        repeat (QUIET_CYCLES) @(posedge clk);
        quiet <= 1'b0;
        write_reg(CTRL, EN_WORD);
        wait_drain();

        $display("beats checked %0d, errors %0d, timeouts %0d", checked, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Run time limit
    initial begin
        #2_000_000;
        $display("simulation stopped, run time limit reached");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: fromhost_dma_if.f
logic/axis_pkg.sv
logic/csr_pkg.sv
logic/fromhost_fifo.sv
logic/axis_upsize_32to64.sv
logic/dma_stream_csr.sv
logic/fromhost_dma_if.sv
sim/fromhost_dma_if_tb.sv

// File: Makefile
# Verilator flow for the host to DMA receive path

VERILATOR ?= verilator
TOP       ?= fromhost_dma_if_tb
RTL_TOP   ?= fromhost_dma_if
FILELIST  ?= fromhost_dma_if.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
